// File: Makefile
# Verilator build and run for the prefetch FIFO testbench

VERILATOR ?= verilator
TB_TOP    ?= prefetch_fifo_tb
RTL_TOP   ?= prefetch_fifo
FILELIST  ?= prefetch_fifo.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only --timing --assert

FAIL_MSG  := *** FAILED ***
PASS_MSG  := *** PASSED ***

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) --Mdir $(BUILD_DIR) -o $(TB_TOP)

run: build
	@./$(BUILD_DIR)/$(TB_TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -qF '$(FAIL_MSG)' $(LOG); then echo "simulation failed, see $(LOG)"; exit 1; fi
	@if ! grep -qF '$(PASS_MSG)' $(LOG); then echo "simulation ended early, see $(LOG)"; exit 1; fi

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: prefetch_fifo.f
+incdir+include
source/prefetch_fifo_pkg.sv
source/fifo_sdpram.sv
source/fifo_ctrl.sv
source/reg_fifo.sv
source/prefetch_fifo.sv
tests/prefetch_fifo_tb.sv

// File: source/fifo_ctrl.sv
`default_nettype none

module fifo_ctrl (
  input  logic                                  rd_clk,        // fifo clock
  input  logic                                  rd_rst,        // async, active high
  input  logic                                  w_en,          // accepted write
  input  logic                                  r_en,          // ram read issue
  output logic [prefetch_fifo_pkg::ADDR_W-1:0]  waddr,         // next write slot
  output logic [prefetch_fifo_pkg::ADDR_W-1:0]  raddr,         // next read slot
  output logic                                  full,          // DEPTH words held
  output logic                                  empty,         // no words held
  output logic [prefetch_fifo_pkg::LEVEL_W-1:0] level,         // ram occupancy
  output logic                                  almost_full,   // level >= ALMOST_FULL_LVL
  output logic                                  almost_empty   // level <= ALMOST_EMPTY_LVL
);

  import prefetch_fifo_pkg::*;

  //////////////////////////////////////////////////
  // pointers with wrap bit
  //////////////////////////////////////////////////
  logic [ADDR_W:0]  wptr_q;              // msb is the wrap bit
  logic [ADDR_W:0]  rptr_q;
  logic [ADDR_W:0]  wptr_d;
  logic [ADDR_W:0]  rptr_d;
  logic [LEVEL_W-1:0] level_d;           // occupancy after this edge
  logic             full_d;
  logic             empty_d;

  assign wptr_d = w_en ? wptr_q + 1'b1 : wptr_q;   // advance on accept
  assign rptr_d = r_en ? rptr_q + 1'b1 : rptr_q;   // advance on issue

  assign waddr = wptr_q[ADDR_W-1:0];     // drop wrap bit
  assign raddr = rptr_q[ADDR_W-1:0];

  always_ff @(posedge rd_clk or posedge rd_rst)
  begin
    if (rd_rst)
    begin
      wptr_q <= '0;
      rptr_q <= '0;
    end
    else
    begin
      wptr_q <= wptr_d;
      rptr_q <= rptr_d;
    end
  end

  //////////////////////////////////////////////////
  // flag logic
  //////////////////////////////////////////////////
  // same index, different lap means full
  assign full_d  = (wptr_d[ADDR_W] != rptr_d[ADDR_W]) &&
                   (wptr_d[ADDR_W-1:0] == rptr_d[ADDR_W-1:0]);
  assign empty_d = (wptr_d == rptr_d);   // same index, same lap
  assign level_d = wptr_d - rptr_d;      // modular difference, 0..DEPTH

  // flags registered from next pointers, so they move with the pointers
  always_ff @(posedge rd_clk or posedge rd_rst)
  begin
    if (rd_rst)
    begin
      full         <= 1'b1;              // keeps wr_ready low in reset
      empty        <= 1'b1;
      level        <= '0;
      almost_full  <= 1'b0;
      almost_empty <= 1'b1;
    end
    else
    begin
      full         <= full_d;
      empty        <= empty_d;
      level        <= level_d;
      almost_full  <= (level_d >= LEVEL_W'(ALMOST_FULL_LVL));
      almost_empty <= (level_d <= LEVEL_W'(ALMOST_EMPTY_LVL));
    end
  end

  //////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////
  // top must gate writes with full
  a_no_write_full: assert property (
    @(posedge rd_clk) disable iff (rd_rst)
    !(w_en && full)
  );

  // prefetch must gate issues with empty
  a_no_read_empty: assert property (
    @(posedge rd_clk) disable iff (rd_rst)
    !(r_en && empty)
  );

endmodule

`default_nettype wire

// File: source/fifo_sdpram.sv
`default_nettype none

module fifo_sdpram (
  input  logic                                 rd_clk,  // single clock for both ports
  input  logic                                 wr_en,   // write strobe
  input  logic [prefetch_fifo_pkg::ADDR_W-1:0] waddr,   // write address
  input  logic [prefetch_fifo_pkg::DATA_W-1:0] wdata,   // write word
  input  logic                                 rd_en,   // read strobe, loads rd_q
  input  logic [prefetch_fifo_pkg::ADDR_W-1:0] raddr,   // read address
  output logic [prefetch_fifo_pkg::DATA_W-1:0] rd_q     // registered read word
);

  import prefetch_fifo_pkg::*;

  //////////////////////////////////////////////////
  // storage array
  //////////////////////////////////////////////////
  logic [DATA_W-1:0] mem [DEPTH];        // maps to block ram

  // write port
  always_ff @(posedge rd_clk)
  begin
    if (wr_en)
    begin
      mem[waddr] <= wdata;               // synchronous write
    end
  end

  //////////////////////////////////////////////////
  // read port
  //////////////////////////////////////////////////
  // data appears on rd_q one edge after rd_en
  // and is held while rd_en stays low
  always_ff @(posedge rd_clk)
  begin
    if (rd_en)
    begin
      rd_q <= mem[raddr];                // read register
    end
  end

  // controller never reads the slot being written,
  // so read-during-write ordering does not matter here

endmodule

`default_nettype wire

// File: source/prefetch_fifo.sv
`default_nettype none

module prefetch_fifo (
  input  logic                                  rd_clk,        // single clock
  input  logic                                  rd_rst,        // async, active high
  input  logic [prefetch_fifo_pkg::DATA_W-1:0]  wr_data,       // producer word
  input  logic                                  wr_valid,      // producer has a word
  output logic                                  wr_ready,      // ram not full
  output logic [prefetch_fifo_pkg::DATA_W-1:0]  rd_data,       // head word, fwft
  input  logic                                  rd_ready,      // consumer takes head
  output logic                                  rd_valid,      // head word present
  output logic [prefetch_fifo_pkg::LEVEL_W-1:0] level,         // ram occupancy
  output logic                                  almost_full,   // ram near full
  output logic                                  almost_empty   // ram near empty
);

  import prefetch_fifo_pkg::*;

  logic              ram_wr_en;          // accepted write
  logic              ram_rd_en;          // read-ahead issue
  logic              rd_issued;          // ram_q valid this cycle
  logic              pop;                // consumer handshake
  logic              full;
  logic              empty;
  logic [ADDR_W-1:0] waddr;
  logic [ADDR_W-1:0] raddr;
  logic [DATA_W-1:0] ram_q;              // registered ram output
  pf_occ_e           occ_q;              // words held or in flight
  pf_occ_e           occ_d;

  //////////////////////////////////////////////////
  // handshakes and issue
  //////////////////////////////////////////////////
  assign wr_ready  = ~full;
  assign ram_wr_en = wr_valid & wr_ready;
  assign pop       = rd_valid & rd_ready;

  // read ahead while a slot is free, or one frees up this cycle
  assign ram_rd_en = ~empty & ((occ_q != PF_TWO) | pop);

  // marks ram data arrival one edge after the issue
  always_ff @(posedge rd_clk or posedge rd_rst)
  begin
    if (rd_rst)
      rd_issued <= 1'b0;
    else
      rd_issued <= ram_rd_en;
  end

  //////////////////////////////////////////////////
  // prefetch occupancy
  //////////////////////////////////////////////////
  always_comb
  begin
    occ_d = occ_q;                       // hold on both or neither
    case ({ram_rd_en, pop})
      2'b10: occ_d = (occ_q == PF_NONE) ? PF_ONE : PF_TWO;   // issue only
      2'b01: occ_d = (occ_q == PF_TWO) ? PF_ONE : PF_NONE;   // pop only
      default: ;
    endcase
  end

  always_ff @(posedge rd_clk or posedge rd_rst)
  begin
    if (rd_rst)
      occ_q <= PF_NONE;
    else
      occ_q <= occ_d;
  end

  //////////////////////////////////////////////////
  // instances
  //////////////////////////////////////////////////
  fifo_sdpram u_ram (
    .rd_clk (rd_clk),
    .wr_en  (ram_wr_en),
    .waddr  (waddr),
    .wdata  (wr_data),
    .rd_en  (ram_rd_en),
    .raddr  (raddr),
    .rd_q   (ram_q)
  );

  fifo_ctrl u_ctrl (
    .rd_clk       (rd_clk),
    .rd_rst       (rd_rst),
    .w_en         (ram_wr_en),
    .r_en         (ram_rd_en),
    .waddr        (waddr),
    .raddr        (raddr),
    .full         (full),
    .empty        (empty),
    .level        (level),
    .almost_full  (almost_full),
    .almost_empty (almost_empty)
  );

  reg_fifo u_out (
    .rd_clk    (rd_clk),
    .rd_rst    (rd_rst),
    .in_valid  (rd_issued),              // one edge after ram_rd_en
    .in_data   (ram_q),
    .out_ready (rd_ready),
    .out_data  (rd_data),
    .out_valid (rd_valid)
  );

  //////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////
  // stalled head must not change under the consumer
  a_stall_hold: assert property (
    @(posedge rd_clk) disable iff (rd_rst)
    (rd_valid && !rd_ready) |=> (rd_valid && $stable(rd_data))
  );

  // in-flight count bounded by the output slots, covers the words on view
  a_occ_bound: assert property (
    @(posedge rd_clk) disable iff (rd_rst)
    (int'(occ_q) <= OUT_SLOTS) &&
    (int'(occ_q) >= int'(rd_valid) + int'(rd_issued))
  );

endmodule

`default_nettype wire

// File: source/prefetch_fifo_pkg.sv
`default_nettype none

package prefetch_fifo_pkg;

  //////////////////////////////////////////////////
  // storage geometry
  //////////////////////////////////////////////////
  localparam int DATA_W  = 8;            // word width
  localparam int ADDR_W  = 11;           // ram address width
  localparam int DEPTH   = 2048;         // ram words
  localparam int LEVEL_W = ADDR_W + 1;   // 0..DEPTH inclusive

  //////////////////////////////////////////////////
  // status thresholds, on ram occupancy
  //////////////////////////////////////////////////
  localparam int ALMOST_FULL_LVL  = DEPTH - 16;  // set at or above
  localparam int ALMOST_EMPTY_LVL = 16;          // set at or below

  // output stage
  localparam int OUT_SLOTS = 2;          // register fifo entries

  // words held in, or on their way to, the register fifo
  typedef enum logic [1:0] {
    PF_NONE = 2'd0,                      // nothing prefetched
    PF_ONE  = 2'd1,                      // one word
    PF_TWO  = 2'd2                       // output stage committed
  } pf_occ_e;

endpackage

`default_nettype wire

// File: source/reg_fifo.sv
`default_nettype none

module reg_fifo (
  input  logic                                 rd_clk,     // fifo clock
  input  logic                                 rd_rst,     // async, active high
  input  logic                                 in_valid,   // ram word arriving
  input  logic [prefetch_fifo_pkg::DATA_W-1:0] in_data,    // ram read data
  input  logic                                 out_ready,  // consumer ready
  output logic [prefetch_fifo_pkg::DATA_W-1:0] out_data,   // head word
  output logic                                 out_valid   // head slot filled
);

  import prefetch_fifo_pkg::*;

  //////////////////////////////////////////////////
  // head and tail slots
  //////////////////////////////////////////////////
  logic [DATA_W-1:0] head_q;             // word shown on out_data
  logic [DATA_W-1:0] tail_q;             // second word, waits behind head
  logic              head_vld;
  logic              tail_vld;           // only set while head_vld
  logic              pop;
  pf_occ_e           held;               // slot count, for the check below

  assign pop       = out_valid & out_ready;
  assign out_valid = head_vld;
  assign out_data  = head_q;
  assign held      = tail_vld ? PF_TWO : (head_vld ? PF_ONE : PF_NONE);

  // slot flags
  always_ff @(posedge rd_clk or posedge rd_rst)
  begin
    if (rd_rst)
    begin
      head_vld <= 1'b0;
      tail_vld <= 1'b0;
    end
    else
    begin
      case ({in_valid, pop})
        2'b10:                           // push only
        begin
          head_vld <= 1'b1;
          tail_vld <= head_vld;          // lands in tail if head taken
        end
        2'b01:                           // pop only
        begin
          head_vld <= tail_vld;          // tail moves up
          tail_vld <= 1'b0;
        end
        default: ;                       // both or neither, count unchanged
      endcase
    end
  end

  // payload slots
  always_ff @(posedge rd_clk)
  begin
    if (pop)
    begin
      head_q <= tail_vld ? tail_q : in_data;   // shift or direct load
      tail_q <= in_data;                 // only meaningful when pushing too
    end
    else if (in_valid)
    begin
      if (!head_vld)
        head_q <= in_data;               // fall through to head
      else
        tail_q <= in_data;
    end
  end

  // prefetch occupancy must keep pushes within two slots
  a_no_overflow: assert property (
    @(posedge rd_clk) disable iff (rd_rst)
    !(in_valid && !pop && held == PF_TWO)
  );

endmodule

`default_nettype wire

// File: include/tb_params.svh
`ifndef TB_PARAMS_SVH
`define TB_PARAMS_SVH

// random stream
localparam int TB_SEED  = 24;            // one seed for $urandom
localparam int TB_WORDS = 6000;          // words in the random phase

// handshake odds, percent per cycle
localparam int TB_VALID_PCT = 70;        // producer drives wr_valid
localparam int TB_READY_PCT = 55;        // consumer drives rd_ready

// watchdog
localparam int TB_TIMEOUT_FACTOR = 40;   // cycles allowed per word

// clock
localparam int TB_CLK_PERIOD = 4;        // ns, full period
localparam int TB_RST_CYCLES = 3;        // reset held this long
localparam int TB_DRIVE_DLY  = 1;        // ns after the rising edge

`endif

// File: tests/prefetch_fifo_tb.sv
`default_nettype none

module prefetch_fifo_tb;

  timeunit 1ns;
  timeprecision 100ps;

  import prefetch_fifo_pkg::*;

  `include "tb_params.svh"

  logic               rd_clk;
  logic               rd_rst;
  logic [DATA_W-1:0]  wr_data;
  logic               wr_valid;
  logic               wr_ready;
  logic [DATA_W-1:0]  rd_data;
  logic               rd_ready;
  logic               rd_valid;
  logic [LEVEL_W-1:0] level;
  logic               almost_full;
  logic               almost_empty;

  logic [DATA_W-1:0]  model [$];         // written, not yet popped
  string              test_name;         // current phase, for error lines
  bit                 wr_acc;            // write handshake at coming edge
  bit                 rd_pop;            // read handshake at coming edge

  prefetch_fifo dut (
    .rd_clk       (rd_clk),
    .rd_rst       (rd_rst),
    .wr_data      (wr_data),
    .wr_valid     (wr_valid),
    .wr_ready     (wr_ready),
    .rd_data      (rd_data),
    .rd_ready     (rd_ready),
    .rd_valid     (rd_valid),
    .level        (level),
    .almost_full  (almost_full),
    .almost_empty (almost_empty)
  );

  //////////////////////////////////////////////////
  // clock and watchdog
  //////////////////////////////////////////////////
  initial
  begin
    rd_clk = 1'b0;
    forever #(TB_CLK_PERIOD / 2) rd_clk = ~rd_clk;   // 4 ns period
  end

  initial
  begin
    #(TB_WORDS * TB_TIMEOUT_FACTOR * TB_CLK_PERIOD);   // generous bound
    fail_run($sformatf("Timeout: the run did not finish, last phase was %s", test_name));
  end

  //////////////////////////////////////////////////
  // reporting
  //////////////////////////////////////////////////
  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("*** FAILED ***");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_value(input string what, input int expected, input int actual);
    assert (actual == expected)
    else
    begin
      fail_run($sformatf("Fail %s (%s): expected 0x%0h, actual 0x%0h",
                         test_name, what, expected, actual));
    end
  endtask

  task automatic check_true(input bit cond, input string msg);
    assert (cond)
    else
    begin
      fail_run(msg);
    end
  endtask

  //////////////////////////////////////////////////
  // cycle helpers
  //////////////////////////////////////////////////
  // inputs change here, outputs already settled
  task automatic next_drive_point();
    @(posedge rd_clk);
    #(TB_DRIVE_DLY);
  endtask

  // mid-cycle look at the handshakes of the coming edge
  task automatic observe();
    @(negedge rd_clk);
    wr_acc = wr_valid && wr_ready;
    rd_pop = rd_valid && rd_ready;
    if (rd_valid)
    begin
      check_true(model.size() > 0, "rd_valid is high although no word is stored");
      if (rd_ready)
        check_value("pop order", int'(model[0]), int'(rd_data));
      else
        check_value("stall hold", int'(model[0]), int'(rd_data));   // head held
      if (rd_pop)
        void'(model.pop_front());
    end
    if (wr_acc)
      model.push_back(wr_data);          // after the pop, order kept
  endtask

  // no handshakes, prefetch runs to its resting state
  task automatic idle_cycles(input int n);
    repeat (n)
    begin
      next_drive_point();
      wr_valid = 1'b0;
      rd_ready = 1'b0;
      observe();
    end
  endtask

  // ram level is the stored count minus words parked in the output stage
  task automatic check_level_flags();
    int held;
    int exp_level;
    idle_cycles(6);
    held      = (model.size() < OUT_SLOTS) ? model.size() : OUT_SLOTS;
    exp_level = model.size() - held;
    check_value("level", exp_level, int'(level));
    check_value("almost_full", int'(exp_level >= ALMOST_FULL_LVL), int'(almost_full));
    check_value("almost_empty", int'(exp_level <= ALMOST_EMPTY_LVL), int'(almost_empty));
    check_value("rd_valid at rest", int'(model.size() > 0), int'(rd_valid));
  endtask

  //////////////////////////////////////////////////
  // test phases
  //////////////////////////////////////////////////
  task automatic run_random();
    int                sent;
    bit                pending;          // offered word not yet taken
    logic [DATA_W-1:0] word;
    sent      = 0;
    pending   = 1'b0;
    word      = '0;
    test_name = "random";
    while (sent < TB_WORDS)
    begin
      next_drive_point();
      if (!pending && (($urandom % 100) < TB_VALID_PCT))
      begin
        pending = 1'b1;
        word    = DATA_W'($urandom);
      end
      wr_valid = pending;
      wr_data  = word;                   // held until accepted
      rd_ready = (($urandom % 100) < TB_READY_PCT);
      observe();
      if (wr_acc)
      begin
        pending = 1'b0;
        sent++;
        if (sent % 750 == 0)
          check_level_flags();           // only between offers
      end
    end
  endtask

  // pop until the output stays empty, then nothing may be left over
  task automatic run_drain();
    int quiet;                           // cycles in a row without rd_valid
    quiet     = 0;
    test_name = "drain";
    while (quiet < 8)
    begin
      next_drive_point();
      wr_valid = 1'b0;
      rd_ready = 1'b1;
      observe();
      quiet = rd_valid ? 0 : quiet + 1;
    end
    check_value("words left in model", 0, model.size());
    check_value("level", 0, int'(level));
    check_value("almost_empty", 1, int'(almost_empty));
    check_value("almost_full", 0, int'(almost_full));
    check_value("wr_ready", 1, int'(wr_ready));
  endtask

  task automatic run_capacity();
    int accepted;
    accepted  = 0;
    test_name = "capacity";
    next_drive_point();
    while (wr_ready && (accepted <= DEPTH + OUT_SLOTS))
    begin
      wr_valid = 1'b1;
      wr_data  = DATA_W'($urandom);      // every offer is taken, ready seen
      rd_ready = 1'b0;
      observe();
      if (wr_acc)
        accepted++;
      next_drive_point();
    end
    wr_valid = 1'b0;
    observe();
    check_value("accepted words", DEPTH + OUT_SLOTS, accepted);
    idle_cycles(6);
    check_value("wr_ready when full", 0, int'(wr_ready));
    check_value("almost_full when full", 1, int'(almost_full));
    check_level_flags();
  endtask

  //////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////
  initial
  begin
    void'($urandom(TB_SEED));            // one seed for the whole run
    rd_rst    = 1'b1;
    wr_valid  = 1'b0;
    wr_data   = '0;
    rd_ready  = 1'b0;
    test_name = "reset";
    @(posedge rd_clk);
    #(TB_DRIVE_DLY);
    check_value("wr_ready in reset", 0, int'(wr_ready));
    repeat (TB_RST_CYCLES - 1) @(posedge rd_clk);
    #(TB_DRIVE_DLY);
    rd_rst = 1'b0;
    idle_cycles(2);                      // full flag clears one edge late
    check_value("wr_ready", 1, int'(wr_ready));
    check_value("rd_valid", 0, int'(rd_valid));
    check_value("level", 0, int'(level));
    check_value("almost_empty", 1, int'(almost_empty));
    check_value("almost_full", 0, int'(almost_full));

    run_random();
    run_drain();
    run_capacity();
    run_drain();

    $display("*** PASSED ***");
    $finish;
  end

endmodule

`default_nettype wire
